// ==== tx_pkg.sv ====
package tx_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes and codes
  ////////////////////////////////////////////////////////////

  localparam int nb_queues       = 4;
  localparam int queue_id_width  = 2;
  localparam int head_width      = 8;
  localparam int flit_bytes      = 64;
  localparam int flit_width      = 512;
  localparam int dwords_per_flit = 16;
  localparam int fifo_depth      = 8;

  // Descriptor ids keep fetch reads apart from packet reads.
  localparam logic [7:0] dsc_tag_id = 8'd2;
  localparam logic [7:0] pkt_tag_id = 8'd1;

  localparam logic [1:0] reg_tail      = 2'd0;
  localparam logic [1:0] reg_base_lo   = 2'd1;
  localparam logic [1:0] reg_base_hi   = 2'd2;
  localparam logic [1:0] reg_ring_size = 2'd3;

  ////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                      valid;
    logic [queue_id_width-1:0] queue;
    logic [1:0]                sel;
    logic [31:0]               data;
  } mmio_wr_t;

  typedef struct packed {
    logic [queue_id_width-1:0] queue;
    logic [head_width-1:0]     head;
    logic [head_width-1:0]     tail;
    logic [63:0]               base;
  } ring_req_t;

  // Destination address of a mover read. Ring state rides in the address.
  typedef struct packed {
    logic [63-1-head_width-queue_id_width-6:0] pad;
    logic                                      dsc;
    logic [head_width-1:0]                     head;
    logic [queue_id_width-1:0]                 queue;
    logic [5:0]                                align;
  } rddm_dst_addr_t;

  typedef struct packed {
    logic [63:0]    src;
    rddm_dst_addr_t dst;
    logic [31:0]    nb_dwords;
    logic [7:0]     dsc_id;
  } rddm_req_t;

  typedef struct packed {
    logic [flit_width-64-32-1:0] pad;
    logic [31:0]                 length;
    logic [63:0]                 addr;
  } tx_dsc_t;

  // One mover word. The address flag says which view holds.
  typedef union packed {
    tx_dsc_t               dsc;
    logic [flit_width-1:0] flit;
  } tx_wr_word_u;

  typedef struct packed {
    logic           valid;
    rddm_dst_addr_t addr;
    tx_wr_word_u    data;
  } rddm_wr_t;

  typedef struct packed {
    logic [queue_id_width-1:0] queue;
    logic [31:0]               total_bytes;
    logic [head_width-1:0]     head;
  } meta_t;

  typedef struct packed {
    logic                  valid;
    logic                  sop;
    logic                  eop;
    logic [flit_width-1:0] data;
  } pkt_out_t;

  typedef struct packed {
    logic                      valid;
    logic [queue_id_width-1:0] queue;
    logic [head_width-1:0]     head;
  } head_upd_t;

endpackage

// ==== tx_sync_fifo.sv ====
`timescale 1ns/1ns

module tx_sync_fifo #(
  parameter type data_t = logic
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  push,
  input  data_t push_data,
  output logic  full,
  input  logic  pop,
  output data_t pop_data,
  output logic  not_empty
);

  data_t                                  mem [tx_pkg::fifo_depth];
  logic [$clog2(tx_pkg::fifo_depth)-1:0]  wr_ptr;
  logic [$clog2(tx_pkg::fifo_depth)-1:0]  rd_ptr;
  logic [$clog2(tx_pkg::fifo_depth):0]    count;
  logic                                   push_ok;
  logic                                   pop_ok;

  assign full      = count == tx_pkg::fifo_depth;
  assign not_empty = count != '0;
  assign push_ok   = push && !full;
  assign pop_ok    = pop && not_empty;
  // Show-ahead read.
  assign pop_data  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_data;
    end
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push_ok && !pop_ok) begin
        count <= count + 1'b1;
      end else if (pop_ok && !push_ok) begin
        count <= count - 1'b1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) !(push && full) && !(pop && !not_empty));

endmodule

// ==== tx_mmio_decode.sv ====
`timescale 1ns/1ns

module tx_mmio_decode (
  input  logic                          clk,
  input  logic                          rst,
  input  tx_pkg::mmio_wr_t              mmio_wr,
  input  logic [tx_pkg::nb_queues-1:0]  ring_busy,
  output tx_pkg::mmio_wr_t              ring_wr [tx_pkg::nb_queues],
  output logic [tx_pkg::head_width:0]   ring_size,
  output logic [tx_pkg::head_width-1:0] ring_mask,
  output logic [31:0]                   ignored_dsc_cnt
);

  logic is_tail;
  logic drop;

  // A tail write to a ring that is still fetching is lost.
  assign is_tail = mmio_wr.valid && mmio_wr.sel == tx_pkg::reg_tail;
  assign drop    = is_tail && ring_busy[mmio_wr.queue];

  always_ff @(posedge clk) begin
    for (int i = 0; i < tx_pkg::nb_queues; i++) begin
      ring_wr[i] <= mmio_wr;
      ring_wr[i].valid <= mmio_wr.valid && !drop && mmio_wr.queue == i &&
                          mmio_wr.sel != tx_pkg::reg_ring_size;
    end
    // Ring size is a power of two.
    ring_mask <= ring_size[tx_pkg::head_width-1:0] - 1'b1;
    if (rst) begin
      for (int i = 0; i < tx_pkg::nb_queues; i++) begin
        ring_wr[i].valid <= 1'b0;
      end
      ring_size       <= {1'b1, {tx_pkg::head_width{1'b0}}};
      ignored_dsc_cnt <= '0;
    end else begin
      if (mmio_wr.valid && mmio_wr.sel == tx_pkg::reg_ring_size) begin
        ring_size <= mmio_wr.data[tx_pkg::head_width:0];
      end
      if (drop) begin
        ignored_dsc_cnt <= ignored_dsc_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== tx_ring_ctx.sv ====
`timescale 1ns/1ns

module tx_ring_ctx (
  input  logic                          clk,
  input  logic                          rst,
  input  tx_pkg::mmio_wr_t              ring_wr,
  input  logic                          ring_ack,
  input  logic [tx_pkg::head_width-1:0] ring_mask,
  output logic                          ring_pend,
  output logic                          ring_busy,
  output tx_pkg::ring_req_t             ring_req
);

  logic [63:0]                       base_q;
  logic [tx_pkg::head_width-1:0]     tail_q;
  logic [tx_pkg::head_width-1:0]     head_q;
  logic [tx_pkg::queue_id_width-1:0] queue_q;
  logic [tx_pkg::head_width-1:0]     new_tail;
  logic                              tail_wr;
  logic                              raise;

  assign new_tail = ring_wr.data[tx_pkg::head_width-1:0] & ring_mask;
  assign tail_wr  = ring_wr.valid && ring_wr.sel == tx_pkg::reg_tail;
  assign raise    = tail_wr && new_tail != head_q;

  // Busy also covers a tail write that lands this cycle.
  assign ring_busy = ring_pend || raise;

  // Head only moves on ack, so it stays frozen while a fetch waits.
  assign ring_req = '{queue: queue_q, head: head_q, tail: tail_q, base: base_q};

  always_ff @(posedge clk) begin
    if (ring_wr.valid && ring_wr.sel == tx_pkg::reg_base_lo) begin
      base_q[31:0] <= ring_wr.data;
    end
    if (ring_wr.valid && ring_wr.sel == tx_pkg::reg_base_hi) begin
      base_q[63:32] <= ring_wr.data;
    end
    if (raise) begin
      queue_q <= ring_wr.queue;
    end
    if (rst) begin
      ring_pend <= 1'b0;
      tail_q    <= '0;
      head_q    <= '0;
    end else begin
      if (tail_wr) begin
        tail_q <= new_tail;
      end
      if (ring_ack) begin
        ring_pend <= 1'b0;
        head_q    <= tail_q;
      end
      if (raise) begin
        ring_pend <= 1'b1;
      end
    end
  end

  // The decoder holds back tail writes for a ring with a fetch in flight.
  assert property (@(posedge clk) disable iff (rst) tail_wr |-> !ring_pend);

endmodule

// ==== tx_fetch_arbiter.sv ====
`timescale 1ns/1ns

module tx_fetch_arbiter (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [tx_pkg::nb_queues-1:0] ring_pend,
  input  tx_pkg::ring_req_t            ring_req [tx_pkg::nb_queues],
  input  logic [tx_pkg::head_width:0]  ring_size,
  input  logic                         dsc_rd_ready,
  output logic [tx_pkg::nb_queues-1:0] ring_ack,
  output logic                         dsc_rd_valid,
  output tx_pkg::rddm_req_t            dsc_rd
);

  logic [tx_pkg::queue_id_width-1:0] last_q;
  logic [tx_pkg::queue_id_width-1:0] grant_q;
  logic                              grant_ok;
  logic                              free;
  logic                              take;
  logic                              wraps;
  logic                              second_pend;
  tx_pkg::ring_req_t                 sel;
  tx_pkg::rddm_req_t                 first_req;
  tx_pkg::rddm_req_t                 second_req;
  tx_pkg::rddm_req_t                 second_q;

  // Round robin. The search starts one past the last grant.
  always_comb begin
    logic [tx_pkg::queue_id_width-1:0] idx;
    grant_ok = 1'b0;
    grant_q  = last_q;
    for (int k = 1; k <= tx_pkg::nb_queues; k++) begin
      idx = last_q + k[tx_pkg::queue_id_width-1:0];
      if (!grant_ok && ring_pend[idx]) begin
        grant_ok = 1'b1;
        grant_q  = idx;
      end
    end
  end

  assign free = !dsc_rd_valid || dsc_rd_ready;
  assign take = free && !second_pend && grant_ok;

  always_comb begin
    ring_ack          = '0;
    ring_ack[grant_q] = take;
  end

  ////////////////////////////////////////////////////////////
  // Request forming
  ////////////////////////////////////////////////////////////

  always_comb begin
    sel   = ring_req[grant_q];
    wraps = !(sel.tail > sel.head);
    first_req           = '0;
    first_req.src       = sel.base + 64'(sel.head) * tx_pkg::flit_bytes;
    first_req.dst.dsc   = 1'b1;
    first_req.dst.head  = sel.head;
    first_req.dst.queue = sel.queue;
    first_req.dsc_id    = tx_pkg::dsc_tag_id;
    if (wraps) begin
      // Read up to the ring end first.
      first_req.nb_dwords = (32'(ring_size) - 32'(sel.head)) * tx_pkg::dwords_per_flit;
    end else begin
      first_req.nb_dwords = 32'(sel.tail - sel.head) * tx_pkg::dwords_per_flit;
    end
    second_req           = first_req;
    second_req.src       = sel.base;
    second_req.dst.head  = '0;
    second_req.nb_dwords = 32'(sel.tail) * tx_pkg::dwords_per_flit;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dsc_rd_valid <= 1'b0;
      second_pend  <= 1'b0;
      last_q       <= '0;
    end else if (free) begin
      if (second_pend) begin
        dsc_rd_valid <= 1'b1;
        dsc_rd       <= second_q;
        second_pend  <= 1'b0;
      end else if (grant_ok) begin
        dsc_rd_valid <= 1'b1;
        dsc_rd       <= first_req;
        second_q     <= second_req;
        second_pend  <= wraps && sel.tail != '0;
        last_q       <= grant_q;
      end else begin
        dsc_rd_valid <= 1'b0;
      end
    end
  end

endmodule

// ==== tx_rddm_sink.sv ====
`timescale 1ns/1ns

module tx_rddm_sink (
  input  logic                          clk,
  input  logic                          rst,
  input  tx_pkg::rddm_wr_t              rddm_wr,
  input  logic [tx_pkg::head_width-1:0] ring_mask,
  output logic                          req_push,
  output tx_pkg::rddm_req_t             req_data,
  output logic                          meta_push,
  output tx_pkg::meta_t                 meta_data,
  output logic                          flit_valid,
  output logic [tx_pkg::flit_width-1:0] flit
);

  tx_pkg::tx_dsc_t                   dsc;
  tx_pkg::rddm_dst_addr_t            dst;
  logic                              is_dsc;
  logic                              new_queue;
  logic                              push_q;
  logic                              last_valid;
  logic [tx_pkg::queue_id_width-1:0] last_queue;
  logic [tx_pkg::head_width-1:0]     last_head;
  logic [tx_pkg::head_width-1:0]     head;

  assign dsc    = rddm_wr.data.dsc;
  assign dst    = rddm_wr.addr;
  assign is_dsc = rddm_wr.valid && dst.dsc;

  // Descriptors of one queue arrive in ring order.
  assign new_queue = !last_valid || dst.queue != last_queue;
  assign head      = new_queue ? dst.head : (last_head + 1'b1) & ring_mask;

  // Packet words go straight on.
  assign flit_valid = rddm_wr.valid && !dst.dsc;
  assign flit       = rddm_wr.data.flit;

  assign req_push  = push_q;
  assign meta_push = push_q;

  always_ff @(posedge clk) begin
    if (is_dsc) begin
      req_data.src       <= dsc.addr;
      req_data.dst       <= dst;
      req_data.dst.dsc   <= 1'b0;
      req_data.nb_dwords <= ((dsc.length - 32'd1) >> 2) + 32'd1;
      req_data.dsc_id    <= tx_pkg::pkt_tag_id;
      meta_data <= '{queue: dst.queue, total_bytes: dsc.length, head: head};
      last_queue <= dst.queue;
      last_head  <= head;
    end
    if (rst) begin
      push_q     <= 1'b0;
      last_valid <= 1'b0;
    end else begin
      push_q <= is_dsc;
      if (is_dsc) begin
        last_valid <= 1'b1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) is_dsc |-> dsc.length != '0);

endmodule

// ==== tx_pkt_emitter.sv ====
`timescale 1ns/1ns

module tx_pkt_emitter (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          flit_valid,
  input  logic [tx_pkg::flit_width-1:0] flit,
  input  logic                          meta_valid,
  input  tx_pkg::meta_t                 meta,
  input  logic [tx_pkg::head_width-1:0] ring_mask,
  output logic                          meta_pop,
  output tx_pkg::pkt_out_t              pkt_out,
  output tx_pkg::head_upd_t             head_upd
);

  logic [31:0]                       pending_q;
  logic [31:0]                       rem;
  logic [31:0]                       next_pending;
  logic                              first;
  logic [tx_pkg::queue_id_width-1:0] cur_queue;
  logic [tx_pkg::queue_id_width-1:0] queue;
  logic [tx_pkg::head_width-1:0]     cur_head;
  logic [tx_pkg::head_width-1:0]     head;

  // No bytes pending means the next flit opens a descriptor.
  assign first    = pending_q == '0;
  assign meta_pop = flit_valid && first && meta_valid;

  always_comb begin
    rem   = first ? meta.total_bytes : pending_q;
    queue = first ? meta.queue : cur_queue;
    head  = first ? meta.head : cur_head;
    // Each flit is a full 64-byte packet.
    next_pending = (rem > tx_pkg::flit_bytes) ? rem - tx_pkg::flit_bytes : '0;
  end

  always_ff @(posedge clk) begin
    pkt_out.sop   <= flit_valid;
    pkt_out.eop   <= flit_valid;
    pkt_out.data  <= flit;
    head_upd.queue <= queue;
    head_upd.head  <= (head + 1'b1) & ring_mask;
    if (flit_valid) begin
      cur_queue <= queue;
      cur_head  <= head;
    end
    if (rst) begin
      pending_q      <= '0;
      pkt_out.valid  <= 1'b0;
      head_upd.valid <= 1'b0;
    end else begin
      pkt_out.valid  <= flit_valid;
      head_upd.valid <= flit_valid && next_pending == '0;
      if (flit_valid) begin
        pending_q <= next_pending;
      end
    end
  end

  // The descriptor write always beats its own packet data.
  assert property (@(posedge clk) disable iff (rst) flit_valid && first |-> meta_valid);

endmodule

// ==== tx_dma_top.sv ====
`timescale 1ns/1ns

module tx_dma_top (
  input  logic              clk,
  input  logic              rst,
  input  tx_pkg::mmio_wr_t  mmio_wr,
  input  logic              dsc_rd_ready,
  input  logic              pkt_rd_ready,
  input  tx_pkg::rddm_wr_t  rddm_wr,
  output logic              dsc_rd_valid,
  output tx_pkg::rddm_req_t dsc_rd,
  output logic              pkt_rd_valid,
  output tx_pkg::rddm_req_t pkt_rd,
  output tx_pkg::pkt_out_t  pkt_out,
  output tx_pkg::head_upd_t head_upd,
  output logic [31:0]       ignored_dsc_cnt
);

  tx_pkg::mmio_wr_t              ring_wr [tx_pkg::nb_queues];
  tx_pkg::ring_req_t             ring_req [tx_pkg::nb_queues];
  logic [tx_pkg::nb_queues-1:0]  ring_busy;
  logic [tx_pkg::nb_queues-1:0]  ring_pend;
  logic [tx_pkg::nb_queues-1:0]  ring_ack;
  logic [tx_pkg::head_width:0]   ring_size;
  logic [tx_pkg::head_width-1:0] ring_mask;
  logic                          req_push;
  tx_pkg::rddm_req_t             req_data;
  logic                          meta_push;
  tx_pkg::meta_t                 meta_data;
  logic                          meta_pop;
  logic                          meta_valid;
  tx_pkg::meta_t                 meta;
  logic                          flit_valid;
  logic [tx_pkg::flit_width-1:0] flit;

  ////////////////////////////////////////////////////////////
  // Descriptor fetch
  ////////////////////////////////////////////////////////////

  tx_mmio_decode decode_i (
    .clk             (clk),
    .rst             (rst),
    .mmio_wr         (mmio_wr),
    .ring_busy       (ring_busy),
    .ring_wr         (ring_wr),
    .ring_size       (ring_size),
    .ring_mask       (ring_mask),
    .ignored_dsc_cnt (ignored_dsc_cnt)
  );

  for (genvar i = 0; i < tx_pkg::nb_queues; i++) begin : g_ring
    tx_ring_ctx ctx_i (
      .clk       (clk),
      .rst       (rst),
      .ring_wr   (ring_wr[i]),
      .ring_ack  (ring_ack[i]),
      .ring_mask (ring_mask),
      .ring_pend (ring_pend[i]),
      .ring_busy (ring_busy[i]),
      .ring_req  (ring_req[i])
    );
  end

  tx_fetch_arbiter arb_i (
    .clk          (clk),
    .rst          (rst),
    .ring_pend    (ring_pend),
    .ring_req     (ring_req),
    .ring_size    (ring_size),
    .dsc_rd_ready (dsc_rd_ready),
    .ring_ack     (ring_ack),
    .dsc_rd_valid (dsc_rd_valid),
    .dsc_rd       (dsc_rd)
  );

  ////////////////////////////////////////////////////////////
  // Mover write path
  ////////////////////////////////////////////////////////////

  tx_rddm_sink sink_i (
    .clk        (clk),
    .rst        (rst),
    .rddm_wr    (rddm_wr),
    .ring_mask  (ring_mask),
    .req_push   (req_push),
    .req_data   (req_data),
    .meta_push  (meta_push),
    .meta_data  (meta_data),
    .flit_valid (flit_valid),
    .flit       (flit)
  );

  tx_sync_fifo #(.data_t(tx_pkg::rddm_req_t)) req_fifo_i (
    .clk       (clk),
    .rst       (rst),
    .push      (req_push),
    .push_data (req_data),
    .full      (),
    .pop       (pkt_rd_valid && pkt_rd_ready),
    .pop_data  (pkt_rd),
    .not_empty (pkt_rd_valid)
  );

  tx_sync_fifo #(.data_t(tx_pkg::meta_t)) meta_fifo_i (
    .clk       (clk),
    .rst       (rst),
    .push      (meta_push),
    .push_data (meta_data),
    .full      (),
    .pop       (meta_pop),
    .pop_data  (meta),
    .not_empty (meta_valid)
  );

  tx_pkt_emitter emit_i (
    .clk        (clk),
    .rst        (rst),
    .flit_valid (flit_valid),
    .flit       (flit),
    .meta_valid (meta_valid),
    .meta       (meta),
    .ring_mask  (ring_mask),
    .meta_pop   (meta_pop),
    .pkt_out    (pkt_out),
    .head_upd   (head_upd)
  );

endmodule

// ==== tb_tx_dma.sv ====
`timescale 1ns/1ns

module tb_tx_dma;

  localparam int cycle_ns       = 100;
  localparam int planned_writes = 24;

  logic                   clk;
  logic                   rst;
  tx_pkg::mmio_wr_t       mmio_wr;
  logic                   dsc_rd_ready;
  logic                   pkt_rd_ready;
  tx_pkg::rddm_wr_t       rddm_wr;
  logic                   dsc_rd_valid;
  tx_pkg::rddm_req_t      dsc_rd;
  logic                   pkt_rd_valid;
  tx_pkg::rddm_req_t      pkt_rd;
  tx_pkg::pkt_out_t       pkt_out;
  tx_pkg::head_upd_t      head_upd;
  logic [31:0]            ignored_dsc_cnt;

  // Reference model state and expected streams.
  tx_pkg::rddm_req_t      exp_dsc [32];
  logic                   exp_follow [32];
  tx_pkg::rddm_req_t      exp_pkt [32];
  logic [511:0]           exp_flit [32];
  logic                   exp_last [32];
  tx_pkg::head_upd_t      exp_upd [32];
  int                     dsc_n;
  int                     pkt_n;
  int                     flit_n;
  int                     upd_n;
  int                     dsc_idx;
  int                     pkt_idx;
  int                     flit_idx;
  int                     upd_idx;
  int                     ring_head [4];
  logic [63:0]            ring_base [4];
  int                     ring_size_m;
  int                     dsc_flits [8];
  int                     nb_dsc;
  logic                   have_last;
  int                     last_q;
  int                     last_head;
  logic                   drop_exp;
  logic [31:0]            ign_exp;
  int                     errors;
  int                     seed = 54;
  tx_pkg::rddm_req_t      dsc_exp;
  tx_pkg::rddm_req_t      pkt_exp;
  tx_pkg::head_upd_t      upd_exp;

  assign dsc_exp = exp_dsc[dsc_idx];
  assign pkt_exp = exp_pkt[pkt_idx];
  assign upd_exp = exp_upd[upd_idx];

  tx_dma_top dut_i (.*);

  always #(cycle_ns / 2) clk = ~clk;

  // Stream positions advance on each transfer.
  always @(posedge clk) begin
    if (rst) begin
      dsc_idx  <= 0;
      pkt_idx  <= 0;
      flit_idx <= 0;
      upd_idx  <= 0;
      ign_exp  <= '0;
    end else begin
      if (dsc_rd_valid && dsc_rd_ready) dsc_idx <= dsc_idx + 1;
      if (pkt_rd_valid && pkt_rd_ready) pkt_idx <= pkt_idx + 1;
      if (pkt_out.valid) flit_idx <= flit_idx + 1;
      if (head_upd.valid) upd_idx <= upd_idx + 1;
      if (mmio_wr.valid && drop_exp) ign_exp <= ign_exp + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic count_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  a_reset: assert property (@(posedge clk) $fell(rst) |-> !dsc_rd_valid && !pkt_rd_valid &&
      !pkt_out.valid && !head_upd.valid && ignored_dsc_cnt == '0)
    else count_failure("Outputs were not idle after reset");
  a_dsc_extra: assert property (@(posedge clk) disable iff (rst)
      dsc_rd_valid && dsc_rd_ready |-> dsc_idx < dsc_n)
    else count_failure("Unexpected descriptor read request");
  a_dsc_value: assert property (@(posedge clk) disable iff (rst)
      dsc_rd_valid && dsc_rd_ready && dsc_idx < dsc_n |-> dsc_rd == dsc_exp)
    else begin
      errors++;
      $display("ERR %0t dsc_rd exp=%h got=%h", $time, $sampled(dsc_exp), $sampled(dsc_rd));
    end
  a_dsc_b2b: assert property (@(posedge clk) disable iff (rst)
      dsc_rd_valid && dsc_rd_ready && dsc_idx + 1 < dsc_n && exp_follow[dsc_idx + 1]
      |=> dsc_rd_valid)
    else count_failure("Second read of a wrapped fetch did not follow back to back");
  a_dsc_hold: assert property (@(posedge clk) disable iff (rst)
      dsc_rd_valid && !dsc_rd_ready |=> dsc_rd_valid && $stable(dsc_rd))
    else count_failure("Descriptor read request changed while stalled");
  a_pkt_extra: assert property (@(posedge clk) disable iff (rst)
      pkt_rd_valid && pkt_rd_ready |-> pkt_idx < pkt_n)
    else count_failure("Unexpected packet read request");
  a_pkt_value: assert property (@(posedge clk) disable iff (rst)
      pkt_rd_valid && pkt_rd_ready && pkt_idx < pkt_n |-> pkt_rd == pkt_exp)
    else begin
      errors++;
      $display("ERR %0t pkt_rd exp=%h got=%h", $time, $sampled(pkt_exp), $sampled(pkt_rd));
    end
  a_pkt_hold: assert property (@(posedge clk) disable iff (rst)
      pkt_rd_valid && !pkt_rd_ready |=> pkt_rd_valid && $stable(pkt_rd))
    else count_failure("Packet read request changed while stalled");
  a_flit_lat: assert property (@(posedge clk) disable iff (rst)
      rddm_wr.valid && !rddm_wr.addr.dsc |=> pkt_out.valid && pkt_out.sop && pkt_out.eop)
    else count_failure("Packet write did not leave one cycle later as a packet");
  a_flit_extra: assert property (@(posedge clk) disable iff (rst)
      pkt_out.valid |-> flit_idx < flit_n)
    else count_failure("Unexpected flit on the packet output");
  a_flit_data: assert property (@(posedge clk) disable iff (rst)
      pkt_out.valid && flit_idx < flit_n |-> pkt_out.data == exp_flit[flit_idx])
    else begin
      errors++;
      $display("ERR %0t pkt_out.data exp=%h got=%h", $time,
               $sampled(exp_flit[flit_idx]), $sampled(pkt_out.data));
    end
  a_upd_when: assert property (@(posedge clk) disable iff (rst)
      pkt_out.valid && flit_idx < flit_n |-> head_upd.valid == exp_last[flit_idx])
    else begin
      errors++;
      $display("ERR %0t head_upd.valid exp=%b got=%b", $time,
               $sampled(exp_last[flit_idx]), $sampled(head_upd.valid));
    end
  a_upd_extra: assert property (@(posedge clk) disable iff (rst)
      head_upd.valid |-> upd_idx < upd_n && pkt_out.valid)
    else count_failure("Head update without a closing flit");
  a_upd_value: assert property (@(posedge clk) disable iff (rst)
      head_upd.valid && upd_idx < upd_n |-> head_upd == upd_exp)
    else begin
      errors++;
      $display("ERR %0t head_upd exp=%h got=%h", $time, $sampled(upd_exp), $sampled(head_upd));
    end
  a_ignored: assert property (@(posedge clk) disable iff (rst) ignored_dsc_cnt == ign_exp)
    else begin
      errors++;
      $display("ERR %0t ignored_dsc_cnt exp=%0d got=%0d", $time,
               $sampled(ign_exp), $sampled(ignored_dsc_cnt));
    end

  ////////////////////////////////////////////////////////////
  // Stimulus and model
  ////////////////////////////////////////////////////////////

  task automatic host_write(input int q, input logic [1:0] sel, input logic [31:0] data,
                            input logic drop);
    @(posedge clk);
    mmio_wr  <= '{valid: 1'b1, queue: 2'(q), sel: sel, data: data};
    drop_exp <= drop;
    @(posedge clk);
    mmio_wr  <= '0;
    drop_exp <= 1'b0;
  endtask

  task automatic set_base(input int q, input logic [63:0] base);
    ring_base[q] = base;
    host_write(q, tx_pkg::reg_base_lo, base[31:0], 1'b0);
    host_write(q, tx_pkg::reg_base_hi, base[63:32], 1'b0);
  endtask

  // Expected read of nb_flits descriptors starting at ring slot head.
  task automatic add_fetch(input int q, input int head, input int nb_flits,
                           input logic follows);
    tx_pkg::rddm_req_t r;
    r           = '0;
    r.src       = ring_base[q] + 64'(head * 64);
    r.dst.dsc   = 1'b1;
    r.dst.head  = 8'(head);
    r.dst.queue = 2'(q);
    r.nb_dwords = 32'(nb_flits * 16);
    r.dsc_id    = 8'd2;
    exp_dsc[dsc_n]    = r;
    exp_follow[dsc_n] = follows;
    dsc_n++;
  endtask

  task automatic post_tail(input int q, input int tail);
    int head;
    head = ring_head[q];
    if (tail > head) begin
      add_fetch(q, head, tail - head, 1'b0);
    end else if (tail != head) begin
      // Wrap splits the span at the ring end.
      add_fetch(q, head, ring_size_m - head, 1'b0);
      if (tail != 0) add_fetch(q, 0, tail, 1'b1);
    end
    ring_head[q] = tail;
    host_write(q, tx_pkg::reg_tail, 32'(tail), 1'b0);
  endtask

  task automatic send_dsc(input int q, input int head, input logic [63:0] addr, input int len);
    tx_pkg::rddm_wr_t  w;
    tx_pkg::rddm_req_t r;
    tx_pkg::head_upd_t u;
    int                h;
    w                 = '0;
    w.valid           = 1'b1;
    w.addr.dsc        = 1'b1;
    w.addr.head       = 8'(head);
    w.addr.queue      = 2'(q);
    w.data.dsc.addr   = addr;
    w.data.dsc.length = 32'(len);
    r           = '0;
    r.src       = addr;
    r.dst.head  = 8'(head);
    r.dst.queue = 2'(q);
    r.nb_dwords = 32'((len + 3) / 4);
    r.dsc_id    = 8'd1;
    exp_pkt[pkt_n] = r;
    pkt_n++;
    // Same queue as before means the next ring slot.
    h = (have_last && q == last_q) ? (last_head + 1) & (ring_size_m - 1) : head;
    have_last = 1'b1;
    last_q    = q;
    last_head = h;
    u = '{valid: 1'b1, queue: 2'(q), head: 8'((h + 1) & (ring_size_m - 1))};
    exp_upd[upd_n] = u;
    upd_n++;
    dsc_flits[nb_dsc] = (len + 63) / 64;
    nb_dsc++;
    @(posedge clk);
    rddm_wr <= w;
  endtask

  task automatic send_flit(input logic last);
    tx_pkg::rddm_wr_t w;
    logic [511:0]     f;
    for (int i = 0; i < 16; i++) f[i*32 +: 32] = $random(seed);
    exp_flit[flit_n] = f;
    exp_last[flit_n] = last;
    flit_n++;
    w           = '0;
    w.valid     = 1'b1;
    w.data.flit = f;
    @(posedge clk);
    rddm_wr <= w;
  endtask

  task automatic wait_drained();
    while (!(dsc_idx == dsc_n && pkt_idx == pkt_n && flit_idx == flit_n && upd_idx == upd_n))
      @(posedge clk);
  endtask

  initial begin
    #(planned_writes * 20 * cycle_ns);
    $display("Timeout, expected traffic did not complete");
    $display("test failed");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    mmio_wr = '0;
    drop_exp = 1'b0;
    dsc_rd_ready = 1'b1;
    pkt_rd_ready = 1'b1;
    rddm_wr = '0;
    errors = 0;
    have_last = 1'b0;
    ring_head = '{0, 0, 0, 0};
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    host_write(0, tx_pkg::reg_ring_size, 32'd16, 1'b0);
    ring_size_m = 16;
    set_base(0, 64'h1_0000_0000);
    set_base(1, 64'h0000_2000);
    // Plain fetch, then a wrap with two reads and one ending at slot 0.
    post_tail(0, 5);
    wait_drained();
    post_tail(0, 3);
    wait_drained();
    post_tail(0, 0);
    wait_drained();
    // Stall the fetch stream so ring 1 stays pending and its next tail is lost.
    @(posedge clk);
    dsc_rd_ready <= 1'b0;
    post_tail(0, 2);
    post_tail(1, 4);
    host_write(1, tx_pkg::reg_tail, 32'd6, 1'b1);
    while (!dsc_rd_valid) @(posedge clk);
    repeat (4) @(posedge clk);
    dsc_rd_ready <= 1'b1;
    wait_drained();
    // Descriptors queue up behind a stalled packet request stream.
    @(posedge clk);
    pkt_rd_ready <= 1'b0;
    send_dsc(0, 5, 64'h1_0000_4000, 128);
    send_dsc(0, 5, 64'h1_0000_8040, 64);
    send_dsc(1, 15, 64'h2_0000_0100, 70);
    send_dsc(1, 15, 64'h0000_3000, 64);
    send_dsc(0, 2, 64'h1_0000_c000, 100);
    @(posedge clk);
    rddm_wr <= '0;
    repeat (3) @(posedge clk);
    pkt_rd_ready <= 1'b1;
    for (int d = 0; d < nb_dsc; d++) begin
      for (int k = 0; k < dsc_flits[d]; k++) send_flit(k == dsc_flits[d] - 1);
    end
    @(posedge clk);
    rddm_wr <= '0;
    wait_drained();
    repeat (10) @(posedge clk);
    $display("errors=%0d fetch_reads=%0d packet_reads=%0d flits=%0d head_updates=%0d",
             errors, dsc_idx, pkt_idx, flit_idx, upd_idx);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
tx_pkg.sv
tx_sync_fifo.sv
tx_mmio_decode.sv
tx_ring_ctx.sv
tx_fetch_arbiter.sv
tx_rddm_sink.sv
tx_pkt_emitter.sv
tx_dma_top.sv
tb_tx_dma.sv

// ==== Makefile ====
# Verilator build for the transmit DMA engine.

VERILATOR ?= verilator
TOP       ?= tb_tx_dma
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= test passed
LINT_ARGS ?= --lint-only -Wall --timing
SIM_ARGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_ARGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only when the pass message shows up as a line of its own.
sim:
	$(VERILATOR) $(SIM_ARGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
